/* hw/dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// ==============================
// Cache geometry
// ==============================
`define DC_XLEN      32          // Processor word width
`define DC_LINE_W    128         // Bits per cache line
`define DC_N_WAYS    4           // Associativity
`define DC_N_SETS    16          // Sets per way
`define DC_WAY_BITS  2           // Way number width

// Address split as tag | set | word | byte
`define DC_BYTE_BITS 2
`define DC_WORD_BITS 2
`define DC_SET_BITS  4
`define DC_SET_LSB   (`DC_BYTE_BITS + `DC_WORD_BITS)   // First set index bit
`define DC_TAG_LSB   (`DC_SET_LSB + `DC_SET_BITS)      // First tag bit
`define DC_TAG_BITS  24

`endif

/* hw/dcache_pkg.sv */
`include "dcache_macros.svh"

package dcache_pkg;

    // ==============================
    // Basic data and address types
    // ==============================
    typedef logic [`DC_XLEN-1:0]     word_t;
    typedef logic [`DC_LINE_W-1:0]   line_t;
    typedef logic [`DC_XLEN-1:0]     addr_t;
    typedef logic [`DC_TAG_BITS-1:0] tag_t;
    typedef logic [`DC_SET_BITS-1:0] set_t;
    typedef logic [`DC_WAY_BITS-1:0] way_t;
    typedef logic [`DC_XLEN/8-1:0]   be_t;

    // Processor request, sampled on p_strobe_i
    typedef struct packed {
        logic  we;      // 1 for store
        be_t   be;      // Byte lanes of the store
        addr_t addr;    // Byte address
        word_t wdata;   // Store data
    } cpu_req_t;

    // Memory request, one whole line per transfer
    typedef struct packed {
        logic  we;      // 1 for write-back
        addr_t addr;    // Line-aligned address
        line_t wline;   // Victim line on a write-back
    } mem_req_t;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,           // Waiting for a processor strobe
        LOOKUP,         // Tag compare, hit response
        WB,             // Dirty victim going out
        REFILL,         // Waiting for the line from memory
        FILL            // Line written into the victim way
    } ctrl_state_t;

endpackage

/* hw/dcache_ram.sv */
`timescale 1ns/1ps

// Single-port RAM with registered read, one entry per set
module dcache_ram #(
    parameter int  N_ENTRIES = 16,
    parameter type payload_t = logic
) (
    input  logic                         clk_i,
    input  logic                         we_i,
    input  logic [$clog2(N_ENTRIES)-1:0] addr_i,
    input  payload_t                     data_i,
    output payload_t                     data_o
);

    payload_t mem [N_ENTRIES];   // Storage array

    // Read returns the old entry when written in the same cycle
    always_ff @(posedge clk_i)
    begin
        if (we_i)
        begin
            mem[addr_i] <= data_i;
        end
        data_o <= mem[addr_i];   // One cycle read latency
    end

endmodule

/* hw/dcache_way_state.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

// Valid, dirty and FIFO replacement state for all sets
module dcache_way_state (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  dcache_pkg::set_t       set_i,         // Set under access
    input  logic                   fill_i,        // Line refilled into fill_way_i
    input  dcache_pkg::way_t       fill_way_i,
    input  logic                   fill_dirty_i,  // Refill carried a store
    input  logic                   mark_dirty_i,  // Store hit on mark_way_i
    input  dcache_pkg::way_t       mark_way_i,
    output logic [`DC_N_WAYS-1:0]  valid_o,
    output logic [`DC_N_WAYS-1:0]  dirty_o,
    output dcache_pkg::way_t       victim_o       // Next way to replace
);

    logic [`DC_N_WAYS-1:0] valid_q [`DC_N_SETS];
    logic [`DC_N_WAYS-1:0] dirty_q [`DC_N_SETS];
    dcache_pkg::way_t      fifo_q  [`DC_N_SETS];  // Oldest way per set
    dcache_pkg::way_t      victim_q;

    // ==============================
    // State update
    // ==============================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < `DC_N_SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                fifo_q[s]  <= '0;
            end
            victim_q <= '0;
        end
        else
        begin
            victim_q <= fifo_q[set_i];                 // Registered, like the RAM read
            if (fill_i)
            begin
                valid_q[set_i][fill_way_i] <= 1'b1;
                dirty_q[set_i][fill_way_i] <= fill_dirty_i;
                fifo_q[set_i]              <= fifo_q[set_i] + dcache_pkg::way_t'(1);  // Wraps
            end
            if (mark_dirty_i)
            begin
                dirty_q[set_i][mark_way_i] <= 1'b1;  // Store hit
            end
        end
    end

    // Flag read is combinational, aligned with the RAM output in LOOKUP
    assign valid_o  = valid_q[set_i];
    assign dirty_o  = dirty_q[set_i];
    assign victim_o = victim_q;

endmodule

/* hw/dcache_line_merge.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

// Word select and byte-enabled store merge on one cache line
module dcache_line_merge (
    input  dcache_pkg::line_t         line_i,
    input  logic [`DC_WORD_BITS-1:0]  offset_i,   // Word within the line
    input  dcache_pkg::be_t           be_i,
    input  dcache_pkg::word_t         wdata_i,
    output dcache_pkg::word_t         word_o,
    output dcache_pkg::line_t         line_o
);

    dcache_pkg::word_t word_sel;   // Addressed word before the store
    dcache_pkg::word_t word_new;   // Addressed word after the store

    // Word 0 sits in the low bits of the line
    always_comb
    begin
        word_sel = line_i[int'(offset_i) * `DC_XLEN +: `DC_XLEN];
    end

    // Any byte-enable pattern is accepted
    always_comb
    begin
        word_new = word_sel;
        for (int b = 0; b < `DC_XLEN / 8; b++)
        begin
            if (be_i[b])
            begin
                word_new[b*8 +: 8] = wdata_i[b*8 +: 8];
            end
        end
    end

    // Rest of the line passes through
    always_comb
    begin
        line_o = line_i;
        line_o[int'(offset_i) * `DC_XLEN +: `DC_XLEN] = word_new;
    end

    assign word_o = word_sel;   // Read data

endmodule

/* hw/dcache_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

// Blocking cache controller FSM
module dcache_ctrl (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    // Processor side
    input  logic                                   p_strobe_i,
    input  dcache_pkg::cpu_req_t                   p_req_i,
    output logic                                   p_ready_o,
    output dcache_pkg::word_t                      p_rdata_o,
    // Memory side
    output logic                                   m_strobe_o,
    output dcache_pkg::mem_req_t                   m_req_o,
    input  logic                                   m_ready_i,
    input  dcache_pkg::line_t                      m_data_i,
    // Tag and line RAMs
    input  dcache_pkg::tag_t  [`DC_N_WAYS-1:0]     tags_i,
    input  dcache_pkg::line_t [`DC_N_WAYS-1:0]     lines_i,
    output dcache_pkg::set_t                       ram_set_o,
    output logic [`DC_N_WAYS-1:0]                  ram_we_o,
    output dcache_pkg::tag_t                       wtag_o,
    output dcache_pkg::line_t                      wline_o,
    // Way state
    input  logic [`DC_N_WAYS-1:0]                  valid_i,
    input  logic [`DC_N_WAYS-1:0]                  dirty_i,
    input  dcache_pkg::way_t                       victim_i,
    output logic                                   fill_o,
    output dcache_pkg::way_t                       fill_way_o,
    output logic                                   fill_dirty_o,
    output logic                                   mark_dirty_o,
    output dcache_pkg::way_t                       mark_way_o,
    // Line merge
    output dcache_pkg::line_t                      merge_line_o,
    output logic [`DC_WORD_BITS-1:0]               merge_offset_o,
    output dcache_pkg::be_t                        merge_be_o,
    output dcache_pkg::word_t                      merge_wdata_o,
    input  dcache_pkg::word_t                      merge_word_i,
    input  dcache_pkg::line_t                      merge_line_i
);

    dcache_pkg::ctrl_state_t state_q, state_d;
    dcache_pkg::cpu_req_t    req_q;          // Request in flight
    dcache_pkg::line_t       line_q;         // Line returned by refill
    dcache_pkg::mem_req_t    mreq_q, mreq_d;
    logic                    mstb_q, mstb_d;
    logic                    accept;         // New request this cycle
    dcache_pkg::tag_t        req_tag;
    dcache_pkg::set_t        req_set;
    logic [`DC_N_WAYS-1:0]   hit_vec;
    logic                    hit;
    dcache_pkg::way_t        hit_way;
    logic                    victim_dirty;

    assign accept  = p_strobe_i && (state_q == dcache_pkg::IDLE);
    assign req_tag = req_q.addr[`DC_XLEN-1 -: `DC_TAG_BITS];
    assign req_set = req_q.addr[`DC_SET_LSB +: `DC_SET_BITS];

    // RAMs see the new set in the strobe cycle, so LOOKUP has fresh data
    assign ram_set_o = accept ? p_req_i.addr[`DC_SET_LSB +: `DC_SET_BITS] : req_set;

    // ==============================
    // Hit detection
    // ==============================
    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < `DC_N_WAYS; w++)
        begin
            hit_vec[w] = valid_i[w] && (tags_i[w] == req_tag);
            if (hit_vec[w])
            begin
                hit_way = dcache_pkg::way_t'(w);   // Ways never share a tag
            end
        end
    end

    assign hit          = |hit_vec;
    assign victim_dirty = valid_i[victim_i] && dirty_i[victim_i];

    // ==============================
    // Next state and memory requests
    // ==============================
    always_comb
    begin
        state_d = state_q;
        mstb_d  = 1'b0;                                  // Strobe lasts one cycle
        mreq_d  = mreq_q;                                // Held until m_ready_i
        case (state_q)
            dcache_pkg::IDLE:
                if (accept) state_d = dcache_pkg::LOOKUP;
            dcache_pkg::LOOKUP:
                if (hit)
                begin
                    state_d = dcache_pkg::IDLE;
                end
                else if (victim_dirty)
                begin
                    state_d      = dcache_pkg::WB;       // Victim goes out first
                    mstb_d       = 1'b1;
                    mreq_d.we    = 1'b1;
                    mreq_d.addr  = {tags_i[victim_i], req_set, {`DC_SET_LSB{1'b0}}};
                    mreq_d.wline = lines_i[victim_i];
                end
                else
                begin
                    state_d      = dcache_pkg::REFILL;
                    mstb_d       = 1'b1;
                    mreq_d.we    = 1'b0;
                    mreq_d.addr  = {req_q.addr[`DC_XLEN-1:`DC_SET_LSB], {`DC_SET_LSB{1'b0}}};
                end
            dcache_pkg::WB:
                if (m_ready_i)
                begin
                    state_d      = dcache_pkg::REFILL;   // Then fetch the new line
                    mstb_d       = 1'b1;
                    mreq_d.we    = 1'b0;
                    mreq_d.addr  = {req_q.addr[`DC_XLEN-1:`DC_SET_LSB], {`DC_SET_LSB{1'b0}}};
                end
            dcache_pkg::REFILL:
                if (m_ready_i) state_d = dcache_pkg::FILL;
            dcache_pkg::FILL:
                state_d = dcache_pkg::IDLE;
            default:
                state_d = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q <= dcache_pkg::IDLE;
            mstb_q  <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            mstb_q  <= mstb_d;
        end
    end

    // Payload registers
    always_ff @(posedge clk_i)
    begin
        mreq_q <= mreq_d;
        if (accept) req_q <= p_req_i;
        if (state_q == dcache_pkg::REFILL && m_ready_i) line_q <= m_data_i;
    end

    assign m_strobe_o = mstb_q;
    assign m_req_o    = mreq_q;

    // ==============================
    // Cache update and response
    // ==============================
    assign merge_line_o   = (state_q == dcache_pkg::FILL) ? line_q : lines_i[hit_way];
    assign merge_offset_o = req_q.addr[`DC_BYTE_BITS +: `DC_WORD_BITS];
    assign merge_be_o     = req_q.be;
    assign merge_wdata_o  = req_q.wdata;

    always_comb
    begin
        ram_we_o = '0;
        if (state_q == dcache_pkg::LOOKUP && req_q.we) ram_we_o = hit_vec;  // Store hit
        if (state_q == dcache_pkg::FILL) ram_we_o[victim_i] = 1'b1;       // Refill
    end

    assign wtag_o       = req_tag;
    assign wline_o      = req_q.we ? merge_line_i : merge_line_o;  // Store merged in
    assign fill_o       = (state_q == dcache_pkg::FILL);
    assign fill_way_o   = victim_i;
    assign fill_dirty_o = req_q.we;
    assign mark_dirty_o = (state_q == dcache_pkg::LOOKUP) && hit && req_q.we;
    assign mark_way_o   = hit_way;

    assign p_ready_o = ((state_q == dcache_pkg::LOOKUP) && hit) || (state_q == dcache_pkg::FILL);
    assign p_rdata_o = merge_word_i;   // Valid with p_ready_o

endmodule

/* hw/dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

// L1 data cache, 4-way, FIFO replacement, write-back
module dcache_top (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  p_strobe_i,
    input  dcache_pkg::cpu_req_t  p_req_i,
    output logic                  p_ready_o,
    output dcache_pkg::word_t     p_rdata_o,
    output logic                  m_strobe_o,
    output dcache_pkg::mem_req_t  m_req_o,
    input  logic                  m_ready_i,
    input  dcache_pkg::line_t     m_data_i
);

    dcache_pkg::tag_t  [`DC_N_WAYS-1:0] tag_rd;    // Tag RAM outputs
    dcache_pkg::line_t [`DC_N_WAYS-1:0] line_rd;   // Line RAM outputs
    dcache_pkg::set_t                   ram_set;
    logic [`DC_N_WAYS-1:0]              ram_we;
    dcache_pkg::tag_t                   wtag;
    dcache_pkg::line_t                  wline;
    logic [`DC_N_WAYS-1:0]              valid;
    logic [`DC_N_WAYS-1:0]              dirty;
    dcache_pkg::way_t                   victim;
    logic                               fill;
    dcache_pkg::way_t                   fill_way;
    logic                               fill_dirty;
    logic                               mark_dirty;
    dcache_pkg::way_t                   mark_way;
    dcache_pkg::line_t                  mrg_line_in;
    dcache_pkg::line_t                  mrg_line_out;
    dcache_pkg::word_t                  mrg_word;
    logic [`DC_WORD_BITS-1:0]           mrg_offset;
    dcache_pkg::be_t                    mrg_be;
    dcache_pkg::word_t                  mrg_wdata;

    dcache_ctrl u_ctrl (
        .clk_i(clk_i), .rst_i(rst_i),
        .p_strobe_i(p_strobe_i), .p_req_i(p_req_i),
        .p_ready_o(p_ready_o), .p_rdata_o(p_rdata_o),
        .m_strobe_o(m_strobe_o), .m_req_o(m_req_o),
        .m_ready_i(m_ready_i), .m_data_i(m_data_i),
        .tags_i(tag_rd), .lines_i(line_rd),
        .ram_set_o(ram_set), .ram_we_o(ram_we), .wtag_o(wtag), .wline_o(wline),
        .valid_i(valid), .dirty_i(dirty), .victim_i(victim),
        .fill_o(fill), .fill_way_o(fill_way), .fill_dirty_o(fill_dirty),
        .mark_dirty_o(mark_dirty), .mark_way_o(mark_way),
        .merge_line_o(mrg_line_in), .merge_offset_o(mrg_offset),
        .merge_be_o(mrg_be), .merge_wdata_o(mrg_wdata),
        .merge_word_i(mrg_word), .merge_line_i(mrg_line_out)
    );

    dcache_way_state u_state (
        .clk_i(clk_i), .rst_i(rst_i), .set_i(ram_set),
        .fill_i(fill), .fill_way_i(fill_way), .fill_dirty_i(fill_dirty),
        .mark_dirty_i(mark_dirty), .mark_way_i(mark_way),
        .valid_o(valid), .dirty_o(dirty), .victim_o(victim)
    );

    dcache_line_merge u_merge (
        .line_i(mrg_line_in), .offset_i(mrg_offset), .be_i(mrg_be),
        .wdata_i(mrg_wdata), .word_o(mrg_word), .line_o(mrg_line_out)
    );

    // ==============================
    // One line RAM and one tag RAM per way
    // ==============================
    for (genvar w = 0; w < `DC_N_WAYS; w++)
    begin : g_way
        dcache_ram #(.N_ENTRIES(`DC_N_SETS), .payload_t(dcache_pkg::line_t)) u_line_ram (
            .clk_i(clk_i), .we_i(ram_we[w]), .addr_i(ram_set),
            .data_i(wline), .data_o(line_rd[w])
        );
        dcache_ram #(.N_ENTRIES(`DC_N_SETS), .payload_t(dcache_pkg::tag_t)) u_tag_ram (
            .clk_i(clk_i), .we_i(ram_we[w]), .addr_i(ram_set),
            .data_i(wtag), .data_o(tag_rd[w])
        );
    end

endmodule

/* verification/dcache_tb.sv */
`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_tb;

    // One processor operation from the trace
    typedef struct packed {
        logic              we;
        dcache_pkg::be_t   be;
        dcache_pkg::addr_t addr;
        dcache_pkg::word_t wdata;
        dcache_pkg::word_t rdata;      // Expected read data, ignored on stores
        logic [1:0]        mem_reqs;   // Expected memory strobes, 0 on a hit
    } trace_op_t;

    localparam int MEM_LINES = 256;    // 4 KB of backing memory

    logic                 clk_i = 1'b0;
    logic                 rst_i;
    logic                 p_strobe_i;
    dcache_pkg::cpu_req_t p_req_i;
    logic                 p_ready_o;
    dcache_pkg::word_t    p_rdata_o;
    logic                 m_strobe_o;
    dcache_pkg::mem_req_t m_req_o;
    logic                 m_ready_i;
    dcache_pkg::line_t    m_data_i;

    trace_op_t            ops [$];
    int                   n_ops;
    int                   mem_strobes;        // Running count of memory strobes
    int                   strobes_at_start;   // Count when the current request began
    dcache_pkg::addr_t    cur_addr;           // Address of the request in flight
    dcache_pkg::line_t    mem_lines [MEM_LINES];

    dcache_top dut_i (
        .clk_i(clk_i), .rst_i(rst_i),
        .p_strobe_i(p_strobe_i), .p_req_i(p_req_i),
        .p_ready_o(p_ready_o), .p_rdata_o(p_rdata_o),
        .m_strobe_o(m_strobe_o), .m_req_o(m_req_o),
        .m_ready_i(m_ready_i), .m_data_i(m_data_i)
    );

    always #2 clk_i = ~clk_i;   // 4 ns period

    task automatic stop_with_error(input string msg);
        $display("Finished with errors");
        $fatal(1, "%s", msg);
    endtask

    // ==============================
    // Memory model
    // ==============================
    initial
    begin
        int unsigned          wait_cnt;
        bit                   busy;
        int                   seed;
        logic [7:0]           idx;
        dcache_pkg::mem_req_t req;

        seed        = 9835;
        busy        = 1'b0;
        wait_cnt    = 0;
        idx         = '0;
        req         = '0;
        mem_strobes = 0;
        m_ready_i   = 1'b0;
        m_data_i    = '0;
        // Every word holds its byte address XOR a constant
        for (int i = 0; i < MEM_LINES; i++)
        begin
            for (int w = 0; w < `DC_LINE_W / `DC_XLEN; w++)
            begin
                mem_lines[i][w*`DC_XLEN +: `DC_XLEN] = (i*16 + w*4) ^ 32'hA5A50000;
            end
        end
        forever
        begin
            @(negedge clk_i);
            m_ready_i = 1'b0;                         // One-cycle answer
            if (busy)
            begin
                assert (!m_strobe_o)
                    else stop_with_error("second memory strobe while one was outstanding");
                if (wait_cnt == 0)
                begin
                    m_ready_i = 1'b1;
                    if (!req.we) m_data_i = mem_lines[idx];   // Refill line
                    busy = 1'b0;
                end
                else
                begin
                    wait_cnt--;
                end
            end
            else if (m_strobe_o)
            begin
                req = m_req_o;
                idx = req.addr[`DC_SET_LSB +: 8];
                assert (req.addr < 32'h1000)
                    else stop_with_error("memory access outside the 4 KB model");
                if (req.we)
                begin
                    // Victim is an aligned line of the requested set
                    assert (req.addr[`DC_SET_LSB-1:0] == '0 &&
                            req.addr[`DC_SET_LSB +: `DC_SET_BITS] ==
                            cur_addr[`DC_SET_LSB +: `DC_SET_BITS])
                        else stop_with_error($sformatf(
                            "error at %0t: m_req_o.addr got %h expected a line of set %h",
                            $time, req.addr, cur_addr[`DC_SET_LSB +: `DC_SET_BITS]));
                    assert (mem_strobes == strobes_at_start)
                        else stop_with_error("write-back came after the refill read");
                    mem_lines[idx] = req.wline;       // Victim line lands in memory
                end
                else
                begin
                    assert (req.addr == {cur_addr[31:`DC_SET_LSB], 4'h0})
                        else stop_with_error($sformatf(
                            "error at %0t: m_req_o.addr got %h expected %h", $time,
                            req.addr, {cur_addr[31:`DC_SET_LSB], 4'h0}));
                end
                mem_strobes++;
                wait_cnt = {$random(seed)} % 6;        // Answer after 1 to 6 cycles
                busy     = 1'b1;
            end
        end
    end

    // ==============================
    // Trace loader and test loop
    // ==============================
    initial
    begin
        int                fd;
        int                code;
        int                cycles;
        logic [8*100-1:0]  line_buf;
        logic [7:0]        op_c;
        dcache_pkg::addr_t addr;
        dcache_pkg::be_t   be;
        dcache_pkg::word_t wdata;
        dcache_pkg::word_t rdata;
        logic [1:0]        mreq;
        trace_op_t         t;

        rst_i            = 1'b1;
        p_strobe_i       = 1'b0;
        p_req_i          = '0;
        cur_addr         = '0;
        strobes_at_start = 0;
        fd = $fopen("verification/dcache_trace.txt", "r");
        if (fd == 0) stop_with_error("could not open verification/dcache_trace.txt");
        while ($fgets(line_buf, fd) > 0)
        begin
            code = $sscanf(line_buf, "%s %h %h %h %h %d", op_c, addr, be, wdata, rdata, mreq);
            if (code == 6)                            // Comment lines parse short
            begin
                assert (op_c == "R" || op_c == "W")
                    else stop_with_error("trace line with an unknown operation");
                t.we       = (op_c == "W");
                t.be       = be;
                t.addr     = addr;
                t.wdata    = wdata;
                t.rdata    = rdata;
                t.mem_reqs = mreq;
                ops.push_back(t);
            end
        end
        $fclose(fd);
        assert (ops.size() > 0) else stop_with_error("trace file holds no operations");
        n_ops = ops.size();

        repeat (5) @(negedge clk_i);
        rst_i = 1'b0;
        assert (!p_ready_o && !m_strobe_o)
            else stop_with_error("p_ready_o or m_strobe_o high after reset");

        foreach (ops[i])
        begin
            t = ops[i];
            @(negedge clk_i);
            assert (!p_ready_o) else stop_with_error("p_ready_o stayed high past one cycle");
            cur_addr         = t.addr;
            strobes_at_start = mem_strobes;
            p_req_i.we       = t.we;
            p_req_i.be       = t.be;
            p_req_i.addr     = t.addr;
            p_req_i.wdata    = t.wdata;
            p_strobe_i       = 1'b1;
            @(negedge clk_i);
            p_strobe_i = 1'b0;                        // Single-cycle strobe
            cycles     = 1;
            while (!p_ready_o)
            begin
                @(negedge clk_i);
                cycles++;
            end
            // Hit or miss from the memory traffic of this request
            assert (mem_strobes - strobes_at_start == int'(t.mem_reqs))
                else stop_with_error($sformatf(
                    "error at %0t: m_strobe_o count got %0d expected %0d (addr %h)", $time,
                    mem_strobes - strobes_at_start, t.mem_reqs, t.addr));
            assert (t.mem_reqs != 0 || cycles == 1)
                else stop_with_error($sformatf(
                    "error at %0t: p_ready_o latency got %0d expected 1 (addr %h)", $time,
                    cycles, t.addr));
            assert (t.we || p_rdata_o == t.rdata)
                else stop_with_error($sformatf(
                    "error at %0t: p_rdata_o got %h expected %h (addr %h)", $time,
                    p_rdata_o, t.rdata, t.addr));
        end
        $display("Finished with no errors");
        $finish;
    end

    // Watchdog, 40 cycles per trace operation plus reset
    initial
    begin
        wait (n_ops != 0);
        repeat (n_ops * 40 + 10) @(posedge clk_i);
        stop_with_error($sformatf("watchdog expired after %0d cycles, DUT stopped answering",
                                  n_ops * 40 + 10));
    end

endmodule

/* verification/dcache_trace.txt */
# op addr be wdata rdata mem  (hex fields; rdata ignored on W)
# mem = memory strobes expected: 0 hit, 1 clean miss, 2 dirty victim write-back then refill
R 00000010 0 00000000 A5A50010 1
R 00000014 0 00000000 A5A50014 0
R 0000001C 0 00000000 A5A5001C 0
W 00000018 1 000000EE 00000000 0
R 00000018 0 00000000 A5A500EE 0
W 0000001A C 12340000 00000000 0
R 00000018 0 00000000 123400EE 0
W 00000024 2 0000BB00 00000000 1
R 00000024 0 00000000 A5A5BB24 0
R 00000020 0 00000000 A5A50020 0
R 00000110 0 00000000 A5A50110 1
W 00000214 3 0000CAFE 00000000 1
R 00000310 0 00000000 A5A50310 1
R 00000014 0 00000000 A5A50014 0
R 00000410 0 00000000 A5A50410 2
R 00000114 0 00000000 A5A50114 0
R 00000018 0 00000000 123400EE 1
R 00000510 0 00000000 A5A50510 2
R 00000214 0 00000000 A5A5CAFE 1
R 00000410 0 00000000 A5A50410 0
R 00000110 0 00000000 A5A50110 1
W 0000033C 8 77000000 00000000 1
R 0000033C 0 00000000 77A5033C 0
W 00000338 5 00110022 00000000 0
R 00000338 0 00000000 A5110322 0

/* src.f */
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_ram.sv
hw/dcache_way_state.sv
hw/dcache_line_merge.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verification/dcache_tb.sv

/* Makefile */
# Verilator simulation of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

# Pass only if the pass message shows up in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
